/* filelist.f */
source/l2_pkg.sv
source/l2_client_arbiter.sv
source/l2_line_store.sv
source/l2_controller.sv
source/l2_mem_port.sv
source/l2_cache_top.sv
tb/tb_clock_gen.sv
tb/l2_cache_asserts.sv
tb/l2_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the L2 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module l2_cache_tb -Mdir obj_dir -o l2_cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/l2_cache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi

/* source/l2_cache_top.sv */
`timescale 1ns/1ns

module l2_cache_top
    import l2_pkg::*;
#(
    parameter int ADDR_W   = L2_ADDR_W,
    parameter int LINE_W   = L2_LINE_W,
    parameter int SET_BITS = L2_SET_BITS
) (
    input  logic              clk,
    input  logic              proc_reset,
    input  logic              l1i_read_i,
    input  logic [ADDR_W-1:0] l1i_addr_i,
    output logic [LINE_W-1:0] l1i_rdata_o,
    output logic              l1i_ready_o,
    input  logic              l1d_read_i,
    input  logic              l1d_write_i,
    input  logic [ADDR_W-1:0] l1d_addr_i,
    input  logic [LINE_W-1:0] l1d_wdata_i,
    output logic [LINE_W-1:0] l1d_rdata_o,
    output logic              l1d_ready_o,
    output logic              mem_read_o,
    output logic              mem_write_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [LINE_W-1:0] mem_wdata_o,
    input  logic [LINE_W-1:0] mem_rdata_i,
    input  logic              mem_ready_i
);

    localparam int TAG_W = ADDR_W - SET_BITS;

    // Arbiter to controller
    logic              req_valid;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [LINE_W-1:0] req_wdata;
    logic              done;
    logic [LINE_W-1:0] resp_rdata;

    // Controller to line store
    logic [SET_BITS-1:0] st_index;
    logic                st_we;
    logic [TAG_W-1:0]    st_wtag;
    logic [LINE_W-1:0]   st_wdata;
    logic                st_wdirty;
    logic [TAG_W-1:0]    st_tag;
    logic                st_valid;
    logic                st_dirty;
    logic [LINE_W-1:0]   st_data;

    // Controller to memory port
    logic              mem_start;
    logic              mem_start_write;
    logic [ADDR_W-1:0] mem_start_addr;
    logic [LINE_W-1:0] mem_start_wdata;
    logic              mem_done;
    logic [LINE_W-1:0] mem_rdata;

    l2_client_arbiter #(
        .ADDR_W (ADDR_W),
        .LINE_W (LINE_W)
    ) l2_client_arbiter_inst (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .l1i_read_i   (l1i_read_i),
        .l1i_addr_i   (l1i_addr_i),
        .l1i_rdata_o  (l1i_rdata_o),
        .l1i_ready_o  (l1i_ready_o),
        .l1d_read_i   (l1d_read_i),
        .l1d_write_i  (l1d_write_i),
        .l1d_addr_i   (l1d_addr_i),
        .l1d_wdata_i  (l1d_wdata_i),
        .l1d_rdata_o  (l1d_rdata_o),
        .l1d_ready_o  (l1d_ready_o),
        .done_i       (done),
        .resp_rdata_i (resp_rdata),
        .req_valid_o  (req_valid),
        .req_client_o (),
        .req_write_o  (req_write),
        .req_addr_o   (req_addr),
        .req_wdata_o  (req_wdata)
    );

    l2_controller #(
        .ADDR_W   (ADDR_W),
        .LINE_W   (LINE_W),
        .SET_BITS (SET_BITS)
    ) l2_controller_inst (
        .clk               (clk),
        .proc_reset        (proc_reset),
        .req_valid_i       (req_valid),
        .req_write_i       (req_write),
        .req_addr_i        (req_addr),
        .req_wdata_i       (req_wdata),
        .done_o            (done),
        .resp_rdata_o      (resp_rdata),
        .st_tag_i          (st_tag),
        .st_valid_i        (st_valid),
        .st_dirty_i        (st_dirty),
        .st_data_i         (st_data),
        .st_index_o        (st_index),
        .st_we_o           (st_we),
        .st_tag_o          (st_wtag),
        .st_data_o         (st_wdata),
        .st_dirty_o        (st_wdirty),
        .mem_done_i        (mem_done),
        .mem_rdata_i       (mem_rdata),
        .mem_start_o       (mem_start),
        .mem_start_write_o (mem_start_write),
        .mem_start_addr_o  (mem_start_addr),
        .mem_start_wdata_o (mem_start_wdata)
    );

    l2_line_store #(
        .ADDR_W   (ADDR_W),
        .LINE_W   (LINE_W),
        .SET_BITS (SET_BITS)
    ) l2_line_store_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index_i    (st_index),
        .we_i       (st_we),
        .tag_i      (st_wtag),
        .data_i     (st_wdata),
        .dirty_i    (st_wdirty),
        .tag_o      (st_tag),
        .valid_o    (st_valid),
        .dirty_o    (st_dirty),
        .data_o     (st_data)
    );

    l2_mem_port #(
        .ADDR_W (ADDR_W),
        .LINE_W (LINE_W)
    ) l2_mem_port_inst (
        .clk           (clk),
        .proc_reset    (proc_reset),
        .start_i       (mem_start),
        .start_write_i (mem_start_write),
        .start_addr_i  (mem_start_addr),
        .start_wdata_i (mem_start_wdata),
        .done_o        (mem_done),
        .rdata_o       (mem_rdata),
        .mem_read_o    (mem_read_o),
        .mem_write_o   (mem_write_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_ready_i   (mem_ready_i)
    );

endmodule

/* source/l2_client_arbiter.sv */
`timescale 1ns/1ns

module l2_client_arbiter
    import l2_pkg::*;
#(
    parameter int ADDR_W = L2_ADDR_W,
    parameter int LINE_W = L2_LINE_W
) (
    input  logic              clk,
    input  logic              proc_reset,
    // Instruction client
    input  logic              l1i_read_i,
    input  logic [ADDR_W-1:0] l1i_addr_i,
    output logic [LINE_W-1:0] l1i_rdata_o,
    output logic              l1i_ready_o,
    // Data client
    input  logic              l1d_read_i,
    input  logic              l1d_write_i,
    input  logic [ADDR_W-1:0] l1d_addr_i,
    input  logic [LINE_W-1:0] l1d_wdata_i,
    output logic [LINE_W-1:0] l1d_rdata_o,
    output logic              l1d_ready_o,
    // Controller side
    input  logic              done_i,
    input  logic [LINE_W-1:0] resp_rdata_i,
    output logic              req_valid_o,
    output client_t           req_client_o,
    output logic              req_write_o,
    output logic [ADDR_W-1:0] req_addr_o,
    output logic [LINE_W-1:0] req_wdata_o
);

    logic    busy;
    client_t grant;
    logic    prio_d;
    logic    want_i;
    logic    want_d;

    // A client that was just answered is still holding its request this cycle
    assign want_i = l1i_read_i && !l1i_ready_o;
    assign want_d = (l1d_read_i || l1d_write_i) && !l1d_ready_o;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            busy        <= 1'b0;
            grant       <= CLIENT_I;
            prio_d      <= 1'b0;
            l1i_ready_o <= 1'b0;
            l1d_ready_o <= 1'b0;
        end else begin
            l1i_ready_o <= 1'b0;
            l1d_ready_o <= 1'b0;
            if (busy) begin
                if (done_i) begin
                    busy   <= 1'b0;
                    prio_d <= ~prio_d;
                    if (grant == CLIENT_I) begin
                        l1i_ready_o <= 1'b1;
                    end else begin
                        l1d_ready_o <= 1'b1;
                    end
                end
            end else if (want_i || want_d) begin
                busy <= 1'b1;
                if (want_i && want_d) begin
                    grant <= prio_d ? CLIENT_D : CLIENT_I;
                end else begin
                    grant <= want_d ? CLIENT_D : CLIENT_I;
                end
            end
        end
    end

    // Response line goes only to the granted client
    always_ff @(posedge clk) begin
        if (busy && done_i) begin
            if (grant == CLIENT_I) begin
                l1i_rdata_o <= resp_rdata_i;
            end else begin
                l1d_rdata_o <= resp_rdata_i;
            end
        end
    end

    // Clients hold address and data stable, so the request is muxed straight through
    assign req_valid_o  = busy;
    assign req_client_o = grant;
    assign req_write_o  = (grant == CLIENT_D) && l1d_write_i;
    assign req_addr_o   = (grant == CLIENT_D) ? l1d_addr_i : l1i_addr_i;
    assign req_wdata_o  = l1d_wdata_i;

endmodule

/* source/l2_controller.sv */
`timescale 1ns/1ns

module l2_controller
    import l2_pkg::*;
#(
    parameter int ADDR_W   = L2_ADDR_W,
    parameter int LINE_W   = L2_LINE_W,
    parameter int SET_BITS = L2_SET_BITS
) (
    input  logic                       clk,
    input  logic                       proc_reset,
    // Granted request
    input  logic                       req_valid_i,
    input  logic                       req_write_i,
    input  logic [ADDR_W-1:0]          req_addr_i,
    input  logic [LINE_W-1:0]          req_wdata_i,
    output logic                       done_o,
    output logic [LINE_W-1:0]          resp_rdata_o,
    // Line store
    input  logic [ADDR_W-SET_BITS-1:0] st_tag_i,
    input  logic                       st_valid_i,
    input  logic                       st_dirty_i,
    input  logic [LINE_W-1:0]          st_data_i,
    output logic [SET_BITS-1:0]        st_index_o,
    output logic                       st_we_o,
    output logic [ADDR_W-SET_BITS-1:0] st_tag_o,
    output logic [LINE_W-1:0]          st_data_o,
    output logic                       st_dirty_o,
    // Memory port
    input  logic                       mem_done_i,
    input  logic [LINE_W-1:0]          mem_rdata_i,
    output logic                       mem_start_o,
    output logic                       mem_start_write_o,
    output logic [ADDR_W-1:0]          mem_start_addr_o,
    output logic [LINE_W-1:0]          mem_start_wdata_o
);

    localparam int TAG_W = ADDR_W - SET_BITS;

    ctrl_state_t       state;
    ctrl_state_t       state_nxt;
    logic [TAG_W-1:0]  req_tag;
    logic              hit;
    logic              victim_dirty;
    logic [LINE_W-1:0] fill_line;

    assign req_tag      = req_addr_i[ADDR_W-1:SET_BITS];
    assign hit          = st_valid_i && (st_tag_i == req_tag);
    assign victim_dirty = st_valid_i && st_dirty_i;

    // A write always leaves the line dirty with the client data in it
    assign fill_line = req_write_i ? req_wdata_i : mem_rdata_i;

    assign st_index_o = req_addr_i[SET_BITS-1:0];
    assign st_tag_o   = req_tag;
    assign st_data_o  = fill_line;
    assign st_dirty_o = req_write_i;

    assign mem_start_wdata_o = st_data_i;
    assign done_o            = (state == RESPOND);

    always_comb begin
        state_nxt         = state;
        st_we_o           = 1'b0;
        mem_start_o       = 1'b0;
        mem_start_write_o = 1'b0;
        mem_start_addr_o  = req_addr_i;
        case (state)
            IDLE: begin
                if (req_valid_i) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    st_we_o   = req_write_i;
                    state_nxt = RESPOND;
                end else if (victim_dirty) begin
                    // Evict the old line to its own address first
                    mem_start_o       = 1'b1;
                    mem_start_write_o = 1'b1;
                    mem_start_addr_o  = {st_tag_i, st_index_o};
                    state_nxt         = WRITEBACK;
                end else begin
                    mem_start_o = 1'b1;
                    state_nxt   = ALLOCATE;
                end
            end
            WRITEBACK: begin
                if (mem_done_i) begin
                    mem_start_o = 1'b1;
                    state_nxt   = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (mem_done_i) begin
                    st_we_o   = 1'b1;
                    state_nxt = RESPOND;
                end
            end
            RESPOND: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Line handed back to the client in RESPOND
    always_ff @(posedge clk) begin
        if (state == LOOKUP && hit) begin
            resp_rdata_o <= req_write_i ? req_wdata_i : st_data_i;
        end else if (state == ALLOCATE && mem_done_i) begin
            resp_rdata_o <= fill_line;
        end
    end

endmodule

/* source/l2_line_store.sv */
`timescale 1ns/1ns

module l2_line_store
    import l2_pkg::*;
#(
    parameter int ADDR_W   = L2_ADDR_W,
    parameter int LINE_W   = L2_LINE_W,
    parameter int SET_BITS = L2_SET_BITS
) (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  logic [SET_BITS-1:0]        index_i,
    input  logic                       we_i,
    input  logic [ADDR_W-SET_BITS-1:0] tag_i,
    input  logic [LINE_W-1:0]          data_i,
    input  logic                       dirty_i,
    output logic [ADDR_W-SET_BITS-1:0] tag_o,
    output logic                       valid_o,
    output logic                       dirty_o,
    output logic [LINE_W-1:0]          data_o
);

    localparam int SETS  = 2 ** SET_BITS;
    localparam int TAG_W = ADDR_W - SET_BITS;

    logic [TAG_W-1:0]  tag_mem   [SETS];
    logic [LINE_W-1:0] data_mem  [SETS];
    logic              dirty_mem [SETS];
    logic [SETS-1:0]   valid_q;

    // Valid bit per set, raised by any write
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[index_i]   <= tag_i;
            data_mem[index_i]  <= data_i;
            dirty_mem[index_i] <= dirty_i;
        end
    end

    // Asynchronous read of the addressed set
    assign tag_o   = tag_mem[index_i];
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_mem[index_i];
    assign data_o  = data_mem[index_i];

endmodule

/* source/l2_mem_port.sv */
`timescale 1ns/1ns

module l2_mem_port
    import l2_pkg::*;
#(
    parameter int ADDR_W = L2_ADDR_W,
    parameter int LINE_W = L2_LINE_W
) (
    input  logic              clk,
    input  logic              proc_reset,
    input  logic              start_i,
    input  logic              start_write_i,
    input  logic [ADDR_W-1:0] start_addr_i,
    input  logic [LINE_W-1:0] start_wdata_i,
    output logic              done_o,
    output logic [LINE_W-1:0] rdata_o,
    output logic              mem_read_o,
    output logic              mem_write_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [LINE_W-1:0] mem_wdata_o,
    input  logic [LINE_W-1:0] mem_rdata_i,
    input  logic              mem_ready_i
);

    logic active;

    assign active = mem_read_o || mem_write_o;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (active && mem_ready_i) begin
                mem_read_o  <= 1'b0;
                mem_write_o <= 1'b0;
                done_o      <= 1'b1;
            end else if (start_i) begin
                mem_read_o  <= !start_write_i;
                mem_write_o <= start_write_i;
            end
        end
    end

    // Address and data stay put for the whole transfer
    always_ff @(posedge clk) begin
        if (start_i && !active) begin
            mem_addr_o  <= start_addr_i;
            mem_wdata_o <= start_wdata_i;
        end
        if (active && mem_ready_i) begin
            rdata_o <= mem_rdata_i;
        end
    end

endmodule

/* source/l2_pkg.sv */
package l2_pkg;

    // Default geometry of the unified L2
    parameter int L2_ADDR_W   = 28;
    parameter int L2_LINE_W   = 128;
    parameter int L2_SET_BITS = 5;

    // Line address and line payload
    typedef logic [L2_ADDR_W-1:0] addr_t;
    typedef logic [L2_LINE_W-1:0] line_t;

    // Client currently being served
    typedef enum logic {
        CLIENT_I,
        CLIENT_D
    } client_t;

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        ALLOCATE,
        RESPOND
    } ctrl_state_t;

endpackage

/* tb/l2_cache_asserts.sv */
`timescale 1ns/1ns

module l2_cache_asserts
    import l2_pkg::*;
#(
    parameter int ADDR_W = L2_ADDR_W,
    parameter int LINE_W = L2_LINE_W
) (
    input logic              clk,
    input logic              proc_reset,
    input logic              l1i_read_i,
    input logic              l1i_ready_i,
    input logic              l1d_read_i,
    input logic              l1d_write_i,
    input logic              l1d_ready_i,
    input logic              mem_read_i,
    input logic              mem_write_i,
    input logic [ADDR_W-1:0] mem_addr_i,
    input logic [LINE_W-1:0] mem_wdata_i,
    input logic              mem_ready_i
);

    strobe_exclusive: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read_i && mem_write_i))
        else $error("memory read and write strobes high together");

    // Memory request held until ready
    mem_request_stable: assert property (@(posedge clk) disable iff (proc_reset)
        ((mem_read_i || mem_write_i) && !mem_ready_i)
        |=> ($stable(mem_addr_i) && $stable(mem_wdata_i)))
        else $error("memory address or data changed during a transfer");

    l1i_ready_needs_request: assert property (@(posedge clk) disable iff (proc_reset)
        l1i_ready_i |-> l1i_read_i)
        else $error("instruction ready without a request");

    l1d_ready_needs_request: assert property (@(posedge clk) disable iff (proc_reset)
        l1d_ready_i |-> (l1d_read_i || l1d_write_i))
        else $error("data ready without a request");

endmodule

bind l2_cache_top l2_cache_asserts #(
    .ADDR_W (ADDR_W),
    .LINE_W (LINE_W)
) l2_cache_asserts_inst (
    .clk         (clk),
    .proc_reset  (proc_reset),
    .l1i_read_i  (l1i_read_i),
    .l1i_ready_i (l1i_ready_o),
    .l1d_read_i  (l1d_read_i),
    .l1d_write_i (l1d_write_i),
    .l1d_ready_i (l1d_ready_o),
    .mem_read_i  (mem_read_o),
    .mem_write_i (mem_write_o),
    .mem_addr_i  (mem_addr_o),
    .mem_wdata_i (mem_wdata_o),
    .mem_ready_i (mem_ready_i)
);

/* tb/l2_cache_tb.sv */
`timescale 1ns/1ns

module l2_cache_tb
    import l2_pkg::*;
();

    localparam int TAG_W       = L2_ADDR_W - L2_SET_BITS;
    localparam int SETS        = 2 ** L2_SET_BITS;
    localparam int HIT_LATENCY = 3;
    // Room for 40 transactions of up to 12 cycles, four times over, plus reset
    localparam int TIMEOUT_CYCLES = 40 * 12 * 4 + 80;

    logic  clk;
    logic  proc_reset;
    logic  l1i_read_i;
    addr_t l1i_addr_i;
    line_t l1i_rdata_o;
    logic  l1i_ready_o;
    logic  l1d_read_i;
    logic  l1d_write_i;
    addr_t l1d_addr_i;
    line_t l1d_wdata_i;
    line_t l1d_rdata_o;
    logic  l1d_ready_o;
    logic  mem_read_o;
    logic  mem_write_o;
    addr_t mem_addr_o;
    line_t mem_wdata_o;
    line_t mem_rdata_i;
    logic  mem_ready_i;

    integer seed = 17;
    int     errors = 0;
    int     checks = 0;
    int     cycle_count = 0;

    // Memory model state
    line_t mem_model [addr_t];
    int    mem_wait = 0;
    int    mem_reads = 0;
    int    mem_writes = 0;
    addr_t last_wr_addr;
    line_t last_wr_data;

    // Reference model of the cache and of memory contents
    logic  ref_valid [SETS];
    addr_t ref_addr  [SETS];
    logic  ref_dirty [SETS];
    line_t ref_data  [SETS];
    line_t golden_mem [addr_t];

    tb_clock_gen #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (10)
    ) tb_clock_gen_inst (
        .clk_o   (clk),
        .reset_o (proc_reset)
    );

    l2_cache_top l2_cache_top_inst (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .l1i_read_i  (l1i_read_i),
        .l1i_addr_i  (l1i_addr_i),
        .l1i_rdata_o (l1i_rdata_o),
        .l1i_ready_o (l1i_ready_o),
        .l1d_read_i  (l1d_read_i),
        .l1d_write_i (l1d_write_i),
        .l1d_addr_i  (l1d_addr_i),
        .l1d_wdata_i (l1d_wdata_i),
        .l1d_rdata_o (l1d_rdata_o),
        .l1d_ready_o (l1d_ready_o),
        .mem_read_o  (mem_read_o),
        .mem_write_o (mem_write_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i)
    );

    // Untouched memory holds its own address repeated across the line
    function automatic line_t addr_pattern(input addr_t a);
        line_t l;
        for (int i = 0; i < L2_LINE_W; i++) begin
            l[i] = a[i % L2_ADDR_W];
        end
        return l;
    endfunction

    function automatic line_t memory_line(input addr_t a);
        return mem_model.exists(a) ? mem_model[a] : addr_pattern(a);
    endfunction

    function automatic line_t golden_line(input addr_t a);
        return golden_mem.exists(a) ? golden_mem[a] : addr_pattern(a);
    endfunction

    function automatic addr_t make_addr(input logic [TAG_W-1:0] tag,
                                        input logic [L2_SET_BITS-1:0] idx);
        return {tag, idx};
    endfunction

    // Memory answers each strobe after 1 to 4 cycles
    always @(negedge clk) begin
        if (mem_ready_i) begin
            mem_ready_i = 1'b0;
        end else if (mem_read_o || mem_write_o) begin
            if (mem_wait == 0) begin
                mem_wait = 1 + ($unsigned($random(seed)) % 4);
            end
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                if (mem_write_o) begin
                    mem_model[mem_addr_o] = mem_wdata_o;
                    last_wr_addr = mem_addr_o;
                    last_wr_data = mem_wdata_o;
                    mem_writes++;
                end else begin
                    mem_rdata_i = memory_line(mem_addr_o);
                    mem_reads++;
                end
                mem_ready_i = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a transaction never completed",
                     TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_line(input string name, input line_t exp, input line_t act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        $display("%-22s %s", name, (errors == errs_at_start) ? "ok" : "FAILED CHECKS");
    endtask

    // One client transaction, predicted by the reference model
    task automatic run_access(input string name, input client_t who, input logic wr,
                              input addr_t a, input line_t wd, input bit solo);
        logic [L2_SET_BITS-1:0] idx;
        logic  hit;
        logic  wb;
        addr_t wb_addr;
        line_t wb_data;
        line_t exp;
        line_t act;
        logic  got;
        int    rd0;
        int    wr0;
        int    cycles;
        idx     = a[L2_SET_BITS-1:0];
        hit     = ref_valid[idx] && (ref_addr[idx] == a);
        wb      = !hit && ref_valid[idx] && ref_dirty[idx];
        wb_addr = ref_addr[idx];
        wb_data = ref_data[idx];
        if (wr) begin
            exp = wd;
        end else if (hit) begin
            exp = ref_data[idx];
        end else begin
            exp = golden_line(a);
        end
        if (wb) begin
            golden_mem[wb_addr] = wb_data;
        end
        ref_dirty[idx] = hit ? (ref_dirty[idx] | wr) : wr;
        ref_valid[idx] = 1'b1;
        ref_addr[idx]  = a;
        ref_data[idx]  = exp;

        @(negedge clk);
        rd0 = mem_reads;
        wr0 = mem_writes;
        if (who == CLIENT_I) begin
            l1i_read_i = 1'b1;
            l1i_addr_i = a;
        end else begin
            l1d_read_i  = !wr;
            l1d_write_i = wr;
            l1d_addr_i  = a;
            l1d_wdata_i = wd;
        end
        @(posedge clk);
        cycles = 0;
        got    = 1'b0;
        while (!got) begin
            @(negedge clk);
            got = (who == CLIENT_I) ? l1i_ready_o : l1d_ready_o;
            if (!got) begin
                cycles++;
            end
        end
        act = (who == CLIENT_I) ? l1i_rdata_o : l1d_rdata_o;
        // Request stays up through the ready cycle
        @(negedge clk);
        if (who == CLIENT_I) begin
            l1i_read_i = 1'b0;
        end else begin
            l1d_read_i  = 1'b0;
            l1d_write_i = 1'b0;
        end

        check_line({name, " rdata"}, exp, act);
        if (solo) begin
            check_count({name, " mem reads"}, hit ? 0 : 1, mem_reads - rd0);
            check_count({name, " mem writes"}, wb ? 1 : 0, mem_writes - wr0);
            if (wb) begin
                check_line({name, " writeback addr"}, line_t'(wb_addr), line_t'(last_wr_addr));
                check_line({name, " writeback data"}, wb_data, last_wr_data);
            end
            if (hit) begin
                check_count({name, " hit latency"}, HIT_LATENCY, cycles);
            end
        end
    endtask

    task automatic reset_and_first_miss();
        int e0;
        e0 = errors;
        checks++;
        if (l1i_ready_o || l1d_ready_o || mem_read_o || mem_write_o) begin
            $display("Outputs not idle after reset: a ready or memory strobe is high");
            errors++;
        end
        run_access("first_miss", CLIENT_I, 1'b0, make_addr(23'd1, 5'd3), '0, 1'b1);
        report_test("reset_and_first_miss", e0);
    endtask

    task automatic same_set_reads();
        int e0;
        e0 = errors;
        run_access("repeat_read", CLIENT_I, 1'b0, make_addr(23'd1, 5'd3), '0, 1'b1);
        run_access("conflict_read", CLIENT_I, 1'b0, make_addr(23'd2, 5'd3), '0, 1'b1);
        run_access("conflict_again", CLIENT_I, 1'b0, make_addr(23'd2, 5'd3), '0, 1'b1);
        run_access("data_side_read", CLIENT_D, 1'b0, make_addr(23'd1, 5'd3), '0, 1'b1);
        run_access("other_set_read", CLIENT_I, 1'b0, make_addr(23'd5, 5'd7), '0, 1'b1);
        report_test("same_set_reads", e0);
    endtask

    task automatic write_hit_read_back();
        int    e0;
        line_t w1;
        e0 = errors;
        w1 = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
        run_access("fill_for_write", CLIENT_D, 1'b0, make_addr(23'd9, 5'd10), '0, 1'b1);
        run_access("write_hit", CLIENT_D, 1'b1, make_addr(23'd9, 5'd10), w1, 1'b1);
        run_access("read_back", CLIENT_D, 1'b0, make_addr(23'd9, 5'd10), '0, 1'b1);
        report_test("write_hit_read_back", e0);
    endtask

    task automatic dirty_eviction();
        int e0;
        e0 = errors;
        run_access("evict_dirty", CLIENT_D, 1'b0, make_addr(23'd11, 5'd10), '0, 1'b1);
        report_test("dirty_eviction", e0);
    endtask

    task automatic write_miss_allocate();
        int    e0;
        line_t w2;
        e0 = errors;
        w2 = {4{32'hc0de_5a5a}};
        run_access("write_miss", CLIENT_D, 1'b1, make_addr(23'd20, 5'd15), w2, 1'b1);
        run_access("evict_written", CLIENT_I, 1'b0, make_addr(23'd21, 5'd15), '0, 1'b1);
        run_access("reload_written", CLIENT_D, 1'b0, make_addr(23'd20, 5'd15), '0, 1'b1);
        report_test("write_miss_allocate", e0);
    endtask

    task automatic dual_client_requests();
        int                     e0;
        logic [31:0]            rnd;
        logic [L2_SET_BITS-1:0] idx_i;
        logic [L2_SET_BITS-1:0] idx_d;
        addr_t                  a_i;
        addr_t                  a_d;
        logic                   dw;
        line_t                  wd;
        e0 = errors;
        for (int n = 0; n < 8; n++) begin
            rnd   = $random(seed);
            idx_i = rnd[4:0];
            // Nonzero offset keeps the two sets apart
            idx_d = idx_i + 5'(1 + (rnd[15:8] % 31));
            a_i   = make_addr(23'(rnd[17:16]), idx_i);
            a_d   = make_addr(23'(rnd[19:18]), idx_d);
            dw    = rnd[20];
            wd    = {4{$random(seed)}};
            fork
                run_access("dual_i", CLIENT_I, 1'b0, a_i, '0, 1'b0);
                run_access("dual_d", CLIENT_D, dw, a_d, wd, 1'b0);
            join
        end
        report_test("dual_client_requests", e0);
    endtask

    initial begin
        l1i_read_i  = 1'b0;
        l1i_addr_i  = '0;
        l1d_read_i  = 1'b0;
        l1d_write_i = 1'b0;
        l1d_addr_i  = '0;
        l1d_wdata_i = '0;
        mem_rdata_i = '0;
        mem_ready_i = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            ref_valid[s] = 1'b0;
            ref_dirty[s] = 1'b0;
        end

        @(negedge proc_reset);
        @(negedge clk);

        reset_and_first_miss();
        same_set_reads();
        write_hit_read_back();
        dirty_eviction();
        write_miss_allocate();
        dual_client_requests();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release reset away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule
